// File: src/spi_pkg.sv
package spi_pkg;

    //////////////////////////////
    // Word and counter sizes
    //////////////////////////////

    localparam int WORD_LEN    = 8;    // Bits per SPI word.
    localparam int BIT_IDX_W   = 4;    // Width of the bit index inside the sck counter.
    localparam int PRESC_W     = 3;    // Width of the prescaler selector.
    localparam int PRESC_CNT_W = 8;    // Holds a half period of up to 256 clock cycles.

    // Value shifted in behind the data, so the line rests high after the last bit.
    localparam logic FILL_BIT = 1'b1;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic [WORD_LEN-1:0] spi_word_t;

    // Per-word configuration, captured together with the data.
    typedef struct packed {
        logic               cpol;       // Idle level of sck.
        logic               cpha;       // Sample on the trailing edge when set.
        logic               lsb_first;  // Shift the least significant bit first.
        logic [PRESC_W-1:0] prescaler;  // Half period is 2**(prescaler+1) cycles.
    } spi_cfg_t;

    // One entry of the transmit holding register.
    typedef struct packed {
        spi_word_t data;
        spi_cfg_t  cfg;
    } tx_entry_t;

    // The three driven SPI pins.
    typedef struct packed {
        logic sck;
        logic mosi;
        logic ss;
    } spi_pins_t;

    // The engine counts half periods as one number.
    // The same bits also read as a bit index plus the half of the sck period.
    typedef union packed {
        logic [BIT_IDX_W:0] count;
        struct packed {
            logic [BIT_IDX_W-1:0] bit_num;  // Index of the bit being transferred.
            logic                 phase;    // 0 before the leading edge, 1 after it.
        } fields;
    } sck_count_u;

endpackage

// File: src/spi_tx_holding.sv
`timescale 1ns/1ps

// One-deep transmit register between the host and the shift engine.
// The host may load the next word while the engine is still busy with the
// current one, so back-to-back words leave no gap on the bus.
module spi_tx_holding (
    input  logic                wr,            // System clock.
    input  logic                rst,           // Asynchronous reset, active high.
    input  logic                tx_write,      // Write strobe from the host.
    input  spi_pkg::spi_word_t  tx_data,       // Word to send.
    input  spi_pkg::spi_cfg_t   cfg,           // Configuration that goes with the word.
    input  logic                clr_send_err,  // Clears the sticky error flag.
    input  logic                take,          // Engine loads the entry this cycle.
    output spi_pkg::tx_entry_t  entry,         // Held word and configuration.
    output logic                entry_valid,   // The register holds a word.
    output logic                tx_empty,      // The host may write.
    output logic                send_err       // A write hit a full register.
);

    logic full;      // Set by an accepted write, cleared when the engine takes it.
    logic accept;    // The write lands in an empty register.
    logic reject;    // The write is dropped.

    assign accept = tx_write & ~full;
    assign reject = tx_write & full;

    //////////////////////////////
    // Occupancy and error flags
    //////////////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            full     <= 1'b0;
            send_err <= 1'b0;
        end else begin
            // The engine only takes when full, so accept and take never meet.
            if (accept) begin
                full <= 1'b1;
            end else if (take) begin
                full <= 1'b0;
            end

            // The clear pulse wins over a new error in the same cycle.
            if (clr_send_err) begin
                send_err <= 1'b0;
            end else if (reject) begin
                send_err <= 1'b1;             // Sticky until the host clears it.
            end
        end
    end

    //////////////////////////////
    // Data and configuration
    //////////////////////////////

    // Prescaler, mode and bit order are frozen with the word.
    // A rejected write therefore leaves the held word as it was.
    always_ff @(posedge wr) begin
        if (accept) begin
            entry.data <= tx_data;
            entry.cfg  <= cfg;
        end
    end

    assign entry_valid = full;
    assign tx_empty    = ~full;                 // High again right after the take.

endmodule

// File: src/spi_shift_engine.sv
`timescale 1ns/1ps

// SPI shift engine.
// It loads one entry from the holding register, runs sixteen half periods of
// sck and reports the received word at the end.
module spi_shift_engine (
    input  logic                wr,           // System clock.
    input  logic                rst,          // Asynchronous reset, active high.
    input  spi_pkg::tx_entry_t  entry,        // Word and configuration to send next.
    input  logic                entry_valid,  // The holding register is full.
    output logic                take,         // Loads the entry at the coming edge.
    input  logic                miso,         // Serial data from the slave.
    output spi_pkg::spi_pins_t  pins,         // sck, mosi and ss.
    output spi_pkg::spi_word_t  rx_word,      // Received word, valid with rx_done.
    output logic                rx_done       // Last half period ends this cycle.
);

    import spi_pkg::*;

    logic                   busy;         // High while a word is on the bus.
    spi_cfg_t               cfg_q;        // Configuration of the word in flight.
    logic [PRESC_CNT_W-1:0] presc_cnt;    // Cycles spent in the current half period.
    logic [PRESC_CNT_W-1:0] presc_limit;  // Last count value of a half period.
    sck_count_u             sck_cnt;      // Half periods done in this word.
    spi_word_t              tx_sh;        // Bits still waiting to go out.
    spi_word_t              rx_sh;        // Bits collected so far.
    spi_word_t              rx_next;      // rx_sh with the current miso bit added.
    logic                   mosi_q;       // Bit currently driven on mosi.
    logic                   tick;         // End of a half period.
    logic                   lead_tick;    // Tick that makes the leading sck edge.
    logic                   trail_tick;   // Tick that makes the trailing sck edge.
    logic                   last_bit;     // The counter sits on the final bit.
    logic                   word_end;     // Trailing edge of the final bit.
    logic                   sample_evt;   // Capture miso now.
    logic                   shift_evt;    // Present the next bit on mosi now.

    // Moves the word one place towards its output end and fills the far end.
    function automatic spi_word_t shift_word(input spi_word_t w, input logic lsb);
        if (lsb) begin
            shift_word = {FILL_BIT, w[WORD_LEN-1:1]};
        end else begin
            shift_word = {w[WORD_LEN-2:0], FILL_BIT};
        end
    endfunction

    // The bit that goes out next for the chosen order.
    function automatic logic out_bit(input spi_word_t w, input logic lsb);
        out_bit = lsb ? w[0] : w[WORD_LEN-1];
    endfunction

    //////////////////////////////
    // Prescaler
    //////////////////////////////

    // A mask of prescaler+1 ones gives 2**(prescaler+1) cycles per half period.
    assign presc_limit = ~({{(PRESC_CNT_W-1){1'b1}}, 1'b0} << cfg_q.prescaler);
    assign tick        = busy & (presc_cnt == presc_limit);

    //////////////////////////////
    // Edge decoding
    //////////////////////////////

    // The phase bit tells which sck edge the tick produces.
    assign lead_tick  = tick & ~sck_cnt.fields.phase;
    assign trail_tick = tick & sck_cnt.fields.phase;
    assign last_bit   = (sck_cnt.fields.bit_num == BIT_IDX_W'(WORD_LEN - 1));
    assign word_end   = trail_tick & last_bit;

    // Mode 0 and 2 sample on the leading edge and shift on the trailing one.
    // Mode 1 and 3 do it the other way round.
    assign sample_evt = cfg_q.cpha ? trail_tick : lead_tick;
    assign shift_evt  = cfg_q.cpha ? lead_tick : (trail_tick & ~last_bit);

    // Idle, or finishing a word with the next one already waiting.
    assign take = entry_valid & (~busy | word_end);

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            busy          <= 1'b0;
            cfg_q         <= '0;            // Keeps sck low after reset.
            presc_cnt     <= '0;
            sck_cnt.count <= '0;
            mosi_q        <= 1'b1;
        end else if (take) begin
            // A new word starts, possibly straight after the previous one.
            busy          <= 1'b1;
            cfg_q         <= entry.cfg;
            presc_cnt     <= '0;
            sck_cnt.count <= '0;
            if (!entry.cfg.cpha) begin
                mosi_q <= out_bit(entry.data, entry.cfg.lsb_first); // First bit before the leading edge.
            end
        end else if (tick) begin
            presc_cnt <= '0;
            if (word_end) begin
                busy          <= 1'b0;      // Nothing waiting, so ss rises.
                sck_cnt.count <= '0;        // sck falls back to cpol.
            end else begin
                sck_cnt.count <= sck_cnt.count + 1'b1;
            end
            if (shift_evt) begin
                mosi_q <= out_bit(tx_sh, cfg_q.lsb_first);
            end
        end else if (busy) begin
            presc_cnt <= presc_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Shift registers
    //////////////////////////////

    // Received bits enter at the end opposite to the one sent first.
    assign rx_next = cfg_q.lsb_first ? {miso, rx_sh[WORD_LEN-1:1]}
                                     : {rx_sh[WORD_LEN-2:0], miso};

    always_ff @(posedge wr) begin
        if (take) begin
            // With cpha clear the first bit is already on mosi, so drop it here.
            tx_sh <= entry.cfg.cpha ? entry.data
                                    : shift_word(entry.data, entry.cfg.lsb_first);
        end else if (shift_evt) begin
            tx_sh <= shift_word(tx_sh, cfg_q.lsb_first);
        end

        if (sample_evt) begin
            rx_sh <= rx_next;               // Eight samples fill the whole register.
        end
    end

    // In modes 1 and 3 the last sample coincides with the end of the word.
    assign rx_word = cfg_q.cpha ? rx_next : rx_sh;
    assign rx_done = word_end;

    //////////////////////////////
    // Pins
    //////////////////////////////

    // sck leaves cpol on the leading edge and returns on the trailing one.
    // mosi rests high whenever no slave is selected.
    assign pins = '{
        sck:  cfg_q.cpol ^ sck_cnt.fields.phase,
        mosi: busy ? mosi_q : 1'b1,
        ss:   ~busy
    };

endmodule

// File: src/spi_rx_holding.sv
`timescale 1ns/1ps

// Receive register on the host side.
// It keeps the last complete word and flags it until the host reads.
module spi_rx_holding (
    input  logic                wr,             // System clock.
    input  logic                rst,            // Asynchronous reset, active high.
    input  spi_pkg::spi_word_t  rx_word,        // Word coming out of the engine.
    input  logic                rx_done,        // rx_word is complete this cycle.
    input  logic                rd,             // Read strobe from the host.
    output spi_pkg::spi_word_t  rx_data,        // Last received word.
    output logic                char_received   // An unread word is waiting.
);

    //////////////////////////////
    // Flag
    //////////////////////////////

    // A word that arrives with the read keeps the flag set.
    // An unread word may be overwritten, and the flag simply stays high.
    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            char_received <= 1'b0;
        end else if (rx_done) begin
            char_received <= 1'b1;
        end else if (rd) begin
            char_received <= 1'b0;   // Falls on the cycle after the read.
        end
    end

    //////////////////////////////
    // Data
    //////////////////////////////

    // The data is always driven, so the host may sample it at any time.
    // It changes in the same cycle as the flag rises.
    always_ff @(posedge wr) begin
        if (rx_done) begin
            rx_data <= rx_word;
        end
    end

endmodule

// File: src/spi_master.sv
`timescale 1ns/1ps

// SPI master for single 8-bit words.
// Host writes go through a one-deep holding register into the shift engine.
// Received words land in a read register with a char-received flag.
module spi_master (
    input  logic                wr,             // System clock.
    input  logic                rst,            // Asynchronous reset, active high.
    input  spi_pkg::spi_word_t  tx_data,        // Word to send.
    input  spi_pkg::spi_cfg_t   cfg,            // Mode, bit order and prescaler.
    input  logic                tx_write,       // Write strobe.
    input  logic                clr_send_err,   // Clears send_err.
    input  logic                rd,             // Read strobe, clears char_received.
    input  logic                miso,           // Serial data from the slave.
    output logic                tx_empty,       // The holding register can take a word.
    output logic                send_err,       // Sticky write-while-full error.
    output spi_pkg::spi_word_t  rx_data,        // Last received word.
    output logic                char_received,  // An unread word is waiting.
    output logic                sck,            // SPI clock.
    output logic                mosi,           // Serial data to the slave.
    output logic                ss              // Slave select, active low.
);

    import spi_pkg::*;

    tx_entry_t entry;        // Held word on its way to the engine.
    logic      entry_valid;
    logic      take;         // Engine loads the held word.
    spi_word_t rx_word;
    logic      rx_done;
    spi_pins_t pins;

    //////////////////////////////
    // Datapath
    //////////////////////////////

    spi_tx_holding tx_hold0 (
        .wr           (wr),
        .rst          (rst),
        .tx_write     (tx_write),
        .tx_data      (tx_data),
        .cfg          (cfg),
        .clr_send_err (clr_send_err),
        .take         (take),
        .entry        (entry),
        .entry_valid  (entry_valid),
        .tx_empty     (tx_empty),
        .send_err     (send_err)
    );

    spi_shift_engine engine0 (
        .wr          (wr),
        .rst         (rst),
        .entry       (entry),
        .entry_valid (entry_valid),
        .take        (take),
        .miso        (miso),
        .pins        (pins),
        .rx_word     (rx_word),
        .rx_done     (rx_done)
    );

    spi_rx_holding rx_hold0 (
        .wr            (wr),
        .rst           (rst),
        .rx_word       (rx_word),
        .rx_done       (rx_done),
        .rd            (rd),
        .rx_data       (rx_data),
        .char_received (char_received)
    );

    // Break the pin bundle out to the package pins.
    assign sck  = pins.sck;
    assign mosi = pins.mosi;
    assign ss   = pins.ss;

endmodule

// File: tests/spi_master_props.sv
`timescale 1ns/1ps

// Protocol properties checked on the ports of the SPI master.
module spi_master_props (
    input logic wr,
    input logic rst,
    input logic tx_write,
    input logic clr_send_err,
    input logic tx_empty,
    input logic send_err,
    input logic mosi,
    input logic ss
);

    //////////////////////////////
    // Properties
    //////////////////////////////

    // An unselected bus keeps mosi at its rest level.
    a_mosi_idle: assert property (@(posedge wr) disable iff (rst) ss |-> mosi)
        else $error("mosi is low while ss is high");

    // An accepted write fills the holding register for at least one cycle.
    a_empty_after_write: assert property (
        @(posedge wr) disable iff (rst) (tx_write && tx_empty) |=> !tx_empty)
        else $error("tx_empty still high after an accepted write");

    // The error flag is sticky.
    a_err_sticky: assert property (
        @(posedge wr) disable iff (rst) $fell(send_err) |-> $past(clr_send_err))
        else $error("send_err fell without a clear pulse");

endmodule

bind spi_master spi_master_props props0 (
    .wr           (wr),
    .rst          (rst),
    .tx_write     (tx_write),
    .clr_send_err (clr_send_err),
    .tx_empty     (tx_empty),
    .send_err     (send_err),
    .mosi         (mosi),
    .ss           (ss)
);

// File: tests/spi_master_tb.sv
`timescale 1ns/1ps

module spi_master_tb;

    import spi_pkg::*;

    logic      wr = 1'b0;
    logic      rst = 1'b1;
    spi_word_t tx_data = '0;
    spi_cfg_t  cfg = '0;
    logic      tx_write = 1'b0;
    logic      clr_send_err = 1'b0;
    logic      rd = 1'b0;
    logic      miso = 1'b1;
    logic      tx_empty, send_err, char_received, sck, mosi, ss;
    spi_word_t rx_data;

    logic [31:0] seed = 32'h11f2_5392;    // Xorshift state.
    int          n_checks = 0;
    int          n_errors = 0;
    int          ss_rises = 0;            // Counts every deselect of the slave.
    spi_cfg_t    scfg = '0;               // Mode the slave model follows.
    spi_word_t   slave_q[$];              // Words the slave answers with.
    spi_word_t   got_q[$];                // Words the slave collected from mosi.

    spi_master dut0 (.*);

    initial begin
        forever #4 wr = ~wr;              // 8 ns period.
    end

    always @(posedge ss) ss_rises++;

    //////////////////////////////
    // Checks and helpers
    //////////////////////////////

    task automatic check_word(input string name, input spi_word_t exp, input spi_word_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        n_checks++;
        if (act != exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic spi_word_t rand_word();
        seed = xorshift(seed);
        return seed[7:0];
    endfunction

    // A wait that ran out of time.
    task automatic timeout_error(input string why);
        n_errors++;
        $display("ERROR at %0t: %s", $time, why);
    endtask

    // Waits until the slave holds n collected words.
    task automatic wait_words(input int n, input int limit);
        int i;
        for (i = 0; i < limit && got_q.size() < n; i++) @(negedge wr);
        if (got_q.size() < n) timeout_error("the slave never received a complete word");
    endtask

    task automatic wait_empty(input int limit);
        int i;
        for (i = 0; i < limit && !tx_empty; i++) @(negedge wr);
        if (!tx_empty) timeout_error("tx_empty never rose again");
    endtask

    task automatic report(input string name, input int errs_before);
        $display("%-26s %s", name, (n_errors == errs_before) ? "ok" : "errors");
    endtask

    //////////////////////////////
    // Slave model
    //////////////////////////////

    int        edges = 0;                 // sck edges seen in this word.
    bit        active = 1'b0;
    spi_word_t s_out, s_in;
    logic      prev_sck = 1'b0, prev_mosi = 1'b1;
    time       last_edge;

    // Puts the next slave bit on miso in the configured order.
    task automatic present_bit();
        miso = scfg.lsb_first ? s_out[0] : s_out[WORD_LEN-1];
        s_out = scfg.lsb_first ? {1'b1, s_out[WORD_LEN-1:1]} : {s_out[WORD_LEN-2:0], 1'b1};
    endtask

    always @(negedge wr) begin
        // The last edge arrives together with the rise of ss, so edges come first.
        if (active && sck !== prev_sck) begin
            edges++;
            if (edges > 1) check_count("sck half period", 8 << (scfg.prescaler + 1),
                                       int'($time - last_edge));
            last_edge = $time;
            if (scfg.cpha ^ edges[0]) begin
                // Sample edge: mosi before the edge is the bit.
                s_in = scfg.lsb_first ? {prev_mosi, s_in[WORD_LEN-1:1]}
                                      : {s_in[WORD_LEN-2:0], prev_mosi};
            end else begin
                present_bit();
            end
            if (edges == 2 * WORD_LEN) begin
                got_q.push_back(s_in);
                active = 1'b0;
            end
        end
        if (ss) begin
            active = 1'b0;
            miso = 1'b1;
        end else if (!active) begin
            active = 1'b1;
            edges = 0;
            s_out = (slave_q.size() > 0) ? slave_q.pop_front() : 8'hff;
            if (!scfg.cpha) present_bit();   // Modes 0 and 2 need the bit early.
        end
        prev_sck = sck;
        prev_mosi = mosi;
    end

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic write_word(input spi_word_t data, input spi_cfg_t c, input spi_word_t swd);
        @(negedge wr);
        slave_q.push_back(swd);
        scfg = c;
        tx_data = data;
        cfg = c;
        tx_write = 1'b1;
        @(negedge wr);
        tx_write = 1'b0;
    endtask

    // Sends one word on an idle bus and checks both directions.
    task automatic run_word(input spi_word_t data, input spi_cfg_t c, input spi_word_t swd);
        write_word(data, c, swd);
        wait_words(1, (32 << c.prescaler) * 2 + 20);
        check_word("mosi word", data, got_q.pop_front());
        check_word("rx_data", swd, rx_data);
        check_bit("char_received", 1'b1, char_received);
        check_bit("ss", 1'b1, ss);
        check_bit("sck", c.cpol, sck);
    endtask

    task automatic read_pulse();
        @(negedge wr) rd = 1'b1;
        @(negedge wr) rd = 1'b0;
        check_bit("char_received", 1'b0, char_received);
    endtask

    task automatic test_reset();
        int e0 = n_errors;
        check_bit("ss", 1'b1, ss);
        check_bit("sck", 1'b0, sck);
        check_bit("mosi", 1'b1, mosi);
        check_bit("tx_empty", 1'b1, tx_empty);
        check_bit("send_err", 1'b0, send_err);
        check_bit("char_received", 1'b0, char_received);
        report("reset values", e0);
    endtask

    task automatic test_modes(input bit lsb, input int presc);
        int e0 = n_errors;
        spi_cfg_t c;
        for (int m = 0; m < 4; m++) begin
            c = '{cpol: m[1], cpha: m[0], lsb_first: lsb, prescaler: PRESC_W'(presc)};
            run_word(rand_word(), c, rand_word());
            read_pulse();
        end
        report($sformatf("modes lsb=%0d presc=%0d", lsb, presc), e0);
    endtask

    task automatic test_back_to_back();
        int e0 = n_errors;
        int rises;
        spi_word_t d1 = rand_word(), d2 = rand_word(), s1 = rand_word(), s2 = rand_word();
        spi_cfg_t c = '{cpol: 1'b1, cpha: 1'b0, lsb_first: 1'b0, prescaler: 3'd1};
        rises = ss_rises;
        write_word(d1, c, s1);
        wait_empty(20);
        write_word(d2, c, s2);
        wait_words(1, 200);
        check_word("rx_data", s1, rx_data);
        wait_words(2, 200);
        check_word("mosi word", d1, got_q.pop_front());
        check_word("mosi word", d2, got_q.pop_front());
        check_word("rx_data", s2, rx_data);
        check_count("ss rises", 1, ss_rises - rises);
        read_pulse();
        report("back-to-back words", e0);
    endtask

    task automatic test_send_error();
        int e0 = n_errors;
        spi_word_t d0 = rand_word(), d1 = rand_word(), s0 = rand_word(), s1 = rand_word();
        spi_cfg_t c = '{cpol: 1'b0, cpha: 1'b1, lsb_first: 1'b1, prescaler: 3'd2};
        write_word(d0, c, s0);
        wait_empty(20);
        write_word(d1, c, s1);            // Held while d0 is still on the bus.
        check_bit("tx_empty", 1'b0, tx_empty);
        tx_data = ~d1;                    // Arrives while the register is still full.
        tx_write = 1'b1;
        @(negedge wr) tx_write = 1'b0;
        check_bit("send_err", 1'b1, send_err);
        wait_words(2, 800);
        check_word("mosi word", d0, got_q.pop_front());
        check_word("mosi word", d1, got_q.pop_front());
        check_bit("send_err", 1'b1, send_err);
        @(negedge wr) clr_send_err = 1'b1;
        @(negedge wr) clr_send_err = 1'b0;
        check_bit("send_err", 1'b0, send_err);
        read_pulse();
        report("send error", e0);
    endtask

    task automatic test_char_flag();
        int e0 = n_errors;
        spi_word_t s2 = rand_word();
        spi_cfg_t c = '{cpol: 1'b0, cpha: 1'b0, lsb_first: 1'b0, prescaler: 3'd0};
        run_word(rand_word(), c, rand_word());
        run_word(rand_word(), c, s2);     // Overwrites the unread word.
        check_word("rx_data", s2, rx_data);
        read_pulse();
        report("char-received flag", e0);
    endtask

    initial begin
        repeat (5) @(negedge wr);
        rst = 1'b0;
        test_reset();
        test_modes(1'b0, 0);
        test_modes(1'b1, 0);
        test_modes(1'b1, 2);
        test_modes(1'b1, 5);
        test_back_to_back();
        test_send_error();
        test_char_flag();
        repeat (4) @(negedge wr);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
src/spi_pkg.sv
src/spi_tx_holding.sv
src/spi_shift_engine.sv
src/spi_rx_holding.sv
src/spi_master.sv
tests/spi_master_props.sv
tests/spi_master_tb.sv

// File: Makefile
# Verilator build for the SPI master testbench.
# Every variable below can be overridden on the command line.

TOP             ?= spi_master_tb
BUILD_DIR       ?= build
LOG             ?= sim.log
FILE_LIST       ?= project.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The log decides the result, so a missing pass line fails the target.
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
